//--- bp_pkg.sv
package bp_pkg;

    // group geometry
    localparam int fetch_width = 2;
    localparam int addr_bits = 32;

    // history length also sets the width of every table index
    localparam int history_bits = 6;
    localparam int pht_size = 64;

    // direct-mapped btb, index taken above the word offset
    localparam int btb_bits = 4;
    localparam int btb_size = 1 << btb_bits;
    localparam int btb_tag_bits = addr_bits - btb_bits - 2;

    // in-flight branch records
    localparam int tracker_depth = 8;
    localparam int tracker_ptr_bits = $clog2(tracker_depth);

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [history_bits-1:0] bhr_t;
    typedef logic [btb_tag_bits-1:0] btb_tag_t;

    // bit 1 set means taken, in the chooser it means prefer gshare
    typedef logic [1:0] counter_t;

    // one prediction, carried until the branch resolves
    typedef struct packed {
        bhr_t gshare_idx;
        bhr_t pc_idx;
        bhr_t bhr;
        logic gshare_taken;
        logic bimodal_taken;
        logic taken;
        addr_t pc;
        addr_t next_pc;
    } bp_packet_t;

    typedef struct packed {
        addr_t start_pc;
        logic [fetch_width-1:0] branch_mask;
    } fetch_req_t;

    typedef struct packed {
        logic [fetch_width-1:0] keep_mask;
        logic [fetch_width-1:0] taken_mask;
        addr_t next_pc;
        bp_packet_t [fetch_width-1:0] packets;
    } fetch_rsp_t;

    typedef struct packed {
        logic taken;
        addr_t target;
    } resolve_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        addr_t target;
    } btb_update_t;

    // hold means the response register is full
    typedef enum logic {
        idle,
        hold
    } ctrl_state_e;

endpackage

//--- btb.sv
module btb (
    input  logic clock,
    input  logic reset,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] lookup_pcs,
    output logic [bp_pkg::fetch_width-1:0] hits,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] targets,
    input  bp_pkg::btb_update_t update
);
    import bp_pkg::*;

    // only the valid bits are control state
    logic [btb_size-1:0] valid;
    btb_tag_t tag_mem [btb_size];
    addr_t target_mem [btb_size];

    // write side fields
    logic [btb_bits-1:0] wr_idx;
    btb_tag_t wr_tag;

    // read side fields, one per slot
    logic [fetch_width-1:0][btb_bits-1:0] rd_idx;
    btb_tag_t [fetch_width-1:0] rd_tag;

    // word aligned pcs, so skip the two low bits
    assign wr_idx = update.pc[btb_bits+1:2];
    assign wr_tag = update.pc[addr_bits-1:btb_bits+2];

    // lookup reads the array as it stood before this edge
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            rd_idx[i] = lookup_pcs[i][btb_bits+1:2];
            rd_tag[i] = lookup_pcs[i][addr_bits-1:btb_bits+2];
            // a hit needs both a live entry and a matching tag
            hits[i] = valid[rd_idx[i]] && (tag_mem[rd_idx[i]] == rd_tag[i]);
            targets[i] = target_mem[rd_idx[i]];
        end
    end

    // all entries start out invalid
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (update.valid) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target are overwritten on every taken resolve
    // an aliasing branch simply replaces the old entry
    always_ff @(posedge clock) begin
        if (update.valid) begin
            tag_mem[wr_idx] <= wr_tag;
            target_mem[wr_idx] <= update.target;
        end
    end

endmodule

//--- tournament_predictor.sv
module tournament_predictor (
    input  logic clock,
    input  logic reset,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] slot_pcs,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::fetch_width-1:0] branch_gnt,
    input  logic [bp_pkg::fetch_width-1:0] final_gnt,
    input  logic no_branches,
    input  logic accept,
    input  logic [bp_pkg::fetch_width-1:0] btb_hits,
    output bp_pkg::bp_packet_t [bp_pkg::fetch_width-1:0] packets,
    output logic [bp_pkg::fetch_width-1:0] taken,
    input  logic resolve_valid,
    input  bp_pkg::bp_packet_t resolve_packet,
    input  logic actual_taken,
    input  logic mispredict
);
    import bp_pkg::*;

    counter_t [pht_size-1:0] gshare_pht;
    counter_t [pht_size-1:0] bimodal_pht;
    counter_t [pht_size-1:0] chooser_pht;
    bhr_t bhr;
    bhr_t accept_bhr;

    // per-slot history, table indices and branch flag
    bhr_t [fetch_width-1:0] assigned_bhr;
    bhr_t [fetch_width-1:0] pc_idx;
    bhr_t [fetch_width-1:0] gs_idx;
    logic [fetch_width-1:0] is_branch;

    // which component got the resolved branch right
    logic gshare_right;
    logic bimodal_right;

    // saturating step toward up or down
    function automatic counter_t step(input counter_t c, input logic up);
        counter_t r;
        r = c;
        if (up && c != 2'b11) begin
            r = c + 2'b01;
        end else if (!up && c != 2'b00) begin
            r = c - 2'b01;
        end
        return r;
    endfunction

    // k-th branch of the group sees the history shifted by k
    // branch_gnt[k] marks the slot holding ordinal k
    always_comb begin
        assigned_bhr = '0;
        is_branch = '0;
        for (int i = 0; i < fetch_width; i++) begin
            for (int k = 0; k < fetch_width; k++) begin
                if (branch_gnt[k][i]) begin
                    assigned_bhr[i] = bhr_t'(bhr << k);
                    is_branch[i] = 1'b1;
                end
            end
        end
    end

    // lookups use the tables as they were before any same-cycle training
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            pc_idx[i] = slot_pcs[i][history_bits+1:2];
            gs_idx[i] = pc_idx[i] ^ assigned_bhr[i];
            packets[i] = '0;
            packets[i].gshare_idx = gs_idx[i];
            packets[i].pc_idx = pc_idx[i];
            packets[i].bhr = assigned_bhr[i];
            packets[i].gshare_taken = gshare_pht[gs_idx[i]][1];
            packets[i].bimodal_taken = bimodal_pht[pc_idx[i]][1];
            packets[i].pc = slot_pcs[i];
            // no target known means no taken prediction
            taken[i] = is_branch[i] && btb_hits[i] &&
                       (chooser_pht[pc_idx[i]][1] ? packets[i].gshare_taken
                                                  : packets[i].bimodal_taken);
            packets[i].taken = taken[i];
        end
    end

    // history after the last kept branch of an accepted group
    always_comb begin
        accept_bhr = bhr;
        for (int i = 0; i < fetch_width; i++) begin
            if (final_gnt[i]) begin
                accept_bhr = {assigned_bhr[i][history_bits-2:0], taken[i]};
            end
        end
    end

    assign gshare_right = (resolve_packet.gshare_taken == actual_taken);
    assign bimodal_right = (resolve_packet.bimodal_taken == actual_taken);

    always_ff @(posedge clock) begin
        if (reset) begin
            gshare_pht <= '0;
            bimodal_pht <= '0;
            chooser_pht <= '0;
            bhr <= '0;
        end else begin
            if (resolve_valid) begin
                gshare_pht[resolve_packet.gshare_idx] <=
                    step(gshare_pht[resolve_packet.gshare_idx], actual_taken);
                bimodal_pht[resolve_packet.pc_idx] <=
                    step(bimodal_pht[resolve_packet.pc_idx], actual_taken);
                // chooser only moves when exactly one side was right
                if (gshare_right != bimodal_right) begin
                    chooser_pht[resolve_packet.pc_idx] <=
                        step(chooser_pht[resolve_packet.pc_idx], gshare_right);
                end
            end
            // repair from a mispredict wins over a new group
            if (resolve_valid && mispredict) begin
                bhr <= {resolve_packet.bhr[history_bits-2:0], actual_taken};
            end else if (accept && !no_branches) begin
                bhr <= accept_bhr;
            end
        end
    end

endmodule

//--- branch_tracker.sv
module branch_tracker (
    input  logic clock,
    input  logic reset,
    input  logic [bp_pkg::fetch_width-1:0] alloc_valid,
    input  bp_pkg::bp_packet_t [bp_pkg::fetch_width-1:0] alloc_packets,
    output logic tracker_free,
    input  logic res_valid,
    input  bp_pkg::resolve_t res,
    output logic res_ready,
    output bp_pkg::bp_packet_t oldest,
    output logic resolve_valid,
    output logic actual_taken,
    output logic mispredict,
    output logic flush,
    output bp_pkg::addr_t flush_pc,
    output bp_pkg::btb_update_t btb_update
);
    import bp_pkg::*;

    bp_packet_t entries [tracker_depth];
    logic [tracker_ptr_bits-1:0] head;
    logic [tracker_ptr_bits-1:0] tail;
    logic [tracker_ptr_bits-1:0] second;
    logic [tracker_ptr_bits:0] count;
    logic [tracker_ptr_bits:0] alloc_count;
    logic [tracker_ptr_bits:0] pop_count;

    // slot 1 lands right after slot 0 when both are kept
    assign second = tail + {{(tracker_ptr_bits-1){1'b0}}, alloc_valid[0]};
    assign alloc_count = {{tracker_ptr_bits{1'b0}}, alloc_valid[0]} +
                         {{tracker_ptr_bits{1'b0}}, alloc_valid[1]};
    assign pop_count = {{tracker_ptr_bits{1'b0}}, resolve_valid};

    // room for a full group
    assign tracker_free = (count <= (tracker_depth - 2));
    assign res_ready = (count != '0);
    assign resolve_valid = res_valid && res_ready;

    assign oldest = entries[head];
    assign actual_taken = res.taken;

    // wrong direction, or taken to somewhere other than predicted
    assign mispredict = (oldest.taken != res.taken) ||
                        (res.taken && (res.target != oldest.next_pc));
    assign flush = resolve_valid && mispredict;
    assign flush_pc = res.taken ? res.target : (oldest.pc + addr_t'(4));

    // every taken outcome (re)installs its target
    assign btb_update.valid = resolve_valid && res.taken;
    assign btb_update.pc = oldest.pc;
    assign btb_update.target = res.target;

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + {{(tracker_ptr_bits-1){1'b0}}, resolve_valid};
            tail <= tail + alloc_count[tracker_ptr_bits-1:0];
            count <= count + alloc_count - pop_count;
        end
    end

    // records themselves
    always_ff @(posedge clock) begin
        if (alloc_valid[0]) begin
            entries[tail] <= alloc_packets[0];
        end
        if (alloc_valid[1]) begin
            entries[second] <= alloc_packets[1];
        end
    end

endmodule

//--- fetch_ctrl.sv
module fetch_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic req_valid,
    input  bp_pkg::fetch_req_t req,
    output logic req_ready,
    output logic rsp_valid,
    output bp_pkg::fetch_rsp_t rsp,
    input  logic rsp_ready,
    output logic redirect_valid,
    output bp_pkg::addr_t redirect_pc,
    output bp_pkg::addr_t [bp_pkg::fetch_width-1:0] slot_pcs,
    output logic [bp_pkg::fetch_width-1:0][bp_pkg::fetch_width-1:0] branch_gnt,
    output logic [bp_pkg::fetch_width-1:0] final_gnt,
    output logic no_branches,
    output logic accept,
    input  logic [bp_pkg::fetch_width-1:0] btb_hits,
    input  bp_pkg::addr_t [bp_pkg::fetch_width-1:0] btb_targets,
    input  bp_pkg::bp_packet_t [bp_pkg::fetch_width-1:0] packets,
    input  logic [bp_pkg::fetch_width-1:0] taken,
    input  logic tracker_free,
    input  logic flush,
    input  bp_pkg::addr_t flush_pc,
    output logic [bp_pkg::fetch_width-1:0] alloc_valid,
    output bp_pkg::bp_packet_t [bp_pkg::fetch_width-1:0] alloc_packets
);
    import bp_pkg::*;

    ctrl_state_e state;
    fetch_rsp_t rsp_q;
    fetch_rsp_t rsp_d;
    logic started;
    logic [fetch_width-1:0] taken_slots;
    logic [fetch_width-1:0] keep_mask;
    logic [fetch_width-1:0] kept_branches;
    addr_t next_pc;

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            slot_pcs[i] = req.start_pc + addr_t'(4 * i);
        end
    end

    // branch ordinals, written out for a two-wide group
    assign branch_gnt[0] = {req.branch_mask[1] & ~req.branch_mask[0], req.branch_mask[0]};
    assign branch_gnt[1] = {req.branch_mask[1] & req.branch_mask[0], 1'b0};

    // group ends at the first taken branch
    assign taken_slots = taken & btb_hits & req.branch_mask;
    assign keep_mask = {~taken_slots[0], 1'b1};
    assign kept_branches = keep_mask & req.branch_mask;
    assign no_branches = ~|kept_branches;

    // line of the youngest kept branch, drives the history update
    assign final_gnt = kept_branches[1] ? 2'b10 : {1'b0, kept_branches[0]};

    always_comb begin
        if (taken_slots[0]) begin
            next_pc = btb_targets[0];
        end else if (taken_slots[1]) begin
            next_pc = btb_targets[1];
        end else begin
            // fall through past the whole group
            next_pc = req.start_pc + addr_t'(4 * fetch_width);
        end
    end

    // per-branch predicted successor, checked again at resolve
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            alloc_packets[i] = packets[i];
            alloc_packets[i].next_pc = taken_slots[i] ? btb_targets[i]
                                                      : (slot_pcs[i] + addr_t'(4));
        end
    end

    assign rsp_d.keep_mask = keep_mask;
    assign rsp_d.taken_mask = taken_slots & keep_mask;
    assign rsp_d.next_pc = next_pc;
    assign rsp_d.packets = alloc_packets;

    // hold off while full, low on tracker space, or redirecting
    assign req_ready = started && ((state == idle) || rsp_ready) && tracker_free &&
                       !flush && !redirect_valid;
    assign accept = req_valid && req_ready;
    assign alloc_valid = accept ? kept_branches : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            started <= 1'b0;
            state <= idle;
            redirect_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            redirect_valid <= flush;
            // a redirect drops whatever response is held
            if (flush) begin
                state <= idle;
            end else if (accept) begin
                state <= hold;
            end else if (rsp_ready) begin
                state <= idle;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
        if (flush) begin
            redirect_pc <= flush_pc;
        end
    end

    assign rsp_valid = (state == hold);
    assign rsp = rsp_q;

endmodule

//--- bp_frontend.sv
module bp_frontend (
    input  logic clock,
    input  logic reset,
    input  logic req_valid,
    input  bp_pkg::fetch_req_t req,
    output logic req_ready,
    output logic rsp_valid,
    output bp_pkg::fetch_rsp_t rsp,
    input  logic rsp_ready,
    input  logic res_valid,
    input  bp_pkg::resolve_t res,
    output logic res_ready,
    output logic redirect_valid,
    output bp_pkg::addr_t redirect_pc
);
    import bp_pkg::*;

    // fetch side
    addr_t [fetch_width-1:0] slot_pcs;
    logic [fetch_width-1:0][fetch_width-1:0] branch_gnt;
    logic [fetch_width-1:0] final_gnt;
    logic no_branches;
    logic accept;
    logic [fetch_width-1:0] btb_hits;
    addr_t [fetch_width-1:0] btb_targets;
    bp_packet_t [fetch_width-1:0] packets;
    logic [fetch_width-1:0] taken;
    logic [fetch_width-1:0] alloc_valid;
    bp_packet_t [fetch_width-1:0] alloc_packets;

    // resolve side
    logic tracker_free;
    bp_packet_t oldest;
    logic resolve_valid;
    logic actual_taken;
    logic mispredict;
    logic flush;
    addr_t flush_pc;
    btb_update_t btb_update;

    fetch_ctrl ctrl (.*);

    btb target_buffer (
        .clock(clock),
        .reset(reset),
        .lookup_pcs(slot_pcs),
        .hits(btb_hits),
        .targets(btb_targets),
        .update(btb_update)
    );

    tournament_predictor predictor (.*, .resolve_packet(oldest));

    branch_tracker tracker (.*);

endmodule

//--- bp_frontend_props.sv
module bp_frontend_props (
    input logic clock,
    input logic reset,
    input bp_pkg::fetch_req_t req,
    input logic req_ready,
    input logic rsp_valid,
    input bp_pkg::fetch_rsp_t rsp,
    input logic rsp_ready,
    input logic res_ready,
    input logic redirect_valid,
    input logic accept,
    input logic flush,
    input logic [bp_pkg::fetch_width-1:0] btb_hits,
    input bp_pkg::addr_t [bp_pkg::fetch_width-1:0] btb_targets
);
    import bp_pkg::*;

    // failed assertions so far, watched by the testbench
    int fail_count = 0;

    // outputs quiet right after reset, req_ready included
    assert property (@(posedge clock)
        reset |=> !rsp_valid && !redirect_valid && !res_ready && !req_ready)
    else begin
        fail_count++;
        $error("outputs not idle after reset");
    end

    // response one cycle after acceptance
    assert property (@(posedge clock) disable iff (reset) accept |=> rsp_valid)
    else begin
        fail_count++;
        $error("no response in the cycle after acceptance");
    end

    // held response stays put unless a redirect drops it
    assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready && !flush |=> rsp_valid && $stable(rsp))
    else begin
        fail_count++;
        $error("held response changed");
    end

    assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |-> !req_ready)
    else begin
        fail_count++;
        $error("req_ready high under back-pressure");
    end

    // a taken slot must be a branch with a btb hit
    assert property (@(posedge clock) disable iff (reset)
        accept |=> (rsp.taken_mask & ~($past(req.branch_mask) & $past(btb_hits))) == '0)
    else begin
        fail_count++;
        $error("taken slot without branch or btb hit");
    end

    // group cut right after the first taken slot
    assert property (@(posedge clock) disable iff (reset)
        accept |=> rsp.keep_mask == (rsp.taken_mask[0] ? 2'b01 : 2'b11))
    else begin
        fail_count++;
        $error("keep mask does not end at the first taken slot");
    end

    assert property (@(posedge clock) disable iff (reset)
        accept |=> rsp.next_pc == (rsp.taken_mask[0] ? $past(btb_targets[0]) :
                                   rsp.taken_mask[1] ? $past(btb_targets[1]) :
                                   $past(req.start_pc) + 32'd8))
    else begin
        fail_count++;
        $error("next pc is neither the taken target nor the fall-through");
    end

    // mispredict gives a single redirect cycle with the response dropped
    assert property (@(posedge clock) disable iff (reset)
        flush |=> redirect_valid && !rsp_valid && !res_ready)
    else begin
        fail_count++;
        $error("mispredict did not redirect and flush");
    end

    assert property (@(posedge clock) disable iff (reset)
        redirect_valid |=> !redirect_valid)
    else begin
        fail_count++;
        $error("redirect longer than one cycle");
    end

endmodule

bind bp_frontend bp_frontend_props props (.*);

//--- bp_frontend_tb.sv
module bp_frontend_tb;
    import bp_pkg::*;

    logic clock;
    logic reset;
    logic req_valid;
    fetch_req_t req;
    logic req_ready;
    logic rsp_valid;
    fetch_rsp_t rsp;
    logic rsp_ready;
    logic res_valid;
    resolve_t res;
    logic res_ready;
    logic redirect_valid;
    addr_t redirect_pc;

    // reference count of in-flight branches
    int outstanding = 0;
    logic group_pending = 1'b0;
    logic [1:0] pending_mask;

    fetch_rsp_t got;
    int lag;
    addr_t pc;
    addr_t target;
    logic [31:0] draw;
    logic [1:0] mask;

    bp_frontend UUT (.*);

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        end_with_failure();
    endtask

    // word aligned random start address
    function automatic addr_t random_pc();
        addr_t r;
        r = $urandom();
        return r & 32'hffff_fffc;
    endfunction

    task automatic send_group(input addr_t start_pc, input logic [1:0] branch_mask,
                              input logic hold_rsp);
        int cycles;
        cycles = 0;
        @(negedge clock);
        req_valid = 1'b1;
        req.start_pc = start_pc;
        req.branch_mask = branch_mask;
        rsp_ready = !hold_rsp;
        @(posedge clock);
        while (!req_ready) begin
            cycles++;
            if (cycles > 100) begin
                timed_out("req_ready");
            end
            @(posedge clock);
        end
        @(negedge clock);
        req_valid = 1'b0;
    endtask

    // extra is the number of cycles past the first one after acceptance
    task automatic wait_response(output fetch_rsp_t seen, output int extra);
        extra = 0;
        @(posedge clock);
        while (!rsp_valid) begin
            extra++;
            if (extra > 100) begin
                timed_out("rsp_valid");
            end
            @(posedge clock);
        end
        seen = rsp;
    endtask

    task automatic resolve_one(input logic is_taken, input addr_t dest);
        int cycles;
        cycles = 0;
        @(negedge clock);
        res_valid = 1'b1;
        res.taken = is_taken;
        res.target = dest;
        @(posedge clock);
        while (!res_ready) begin
            cycles++;
            if (cycles > 100) begin
                timed_out("res_ready");
            end
            @(posedge clock);
        end
        @(negedge clock);
        res_valid = 1'b0;
    endtask

    // resolve n branches as not taken, then the tracker must be empty
    task automatic drain(input int n);
        for (int i = 0; i < n; i++) begin
            resolve_one(1'b0, '0);
        end
        check_value("drain_res_ready", 0, 32'(res_ready));
    endtask

    task automatic check_redirect(input string name, input addr_t dest);
        check_value({name, "_redirect_valid"}, 1, 32'(redirect_valid));
        check_value({name, "_redirect_pc"}, dest, redirect_pc);
        check_value({name, "_rsp_valid"}, 0, 32'(rsp_valid));
        check_value({name, "_res_ready"}, 0, 32'(res_ready));
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // posedge reads see values from before the edge
    always @(posedge clock) begin
        if (reset) begin
            outstanding = 0;
            group_pending = 1'b0;
        end else begin
            if (redirect_valid) begin
                outstanding = 0;
            end
            // kept branches of the last accepted group
            if (group_pending) begin
                outstanding += $countones(rsp.keep_mask & pending_mask);
            end
            group_pending = 1'b0;
            check_value("tracker_res_ready", 32'(outstanding != 0), 32'(res_ready));
            assert (!req_ready || outstanding <= tracker_depth - 2) else begin
                $display("req_ready high with fewer than two free tracker entries");
                end_with_failure();
            end
            if (req_valid && req_ready) begin
                group_pending = 1'b1;
                pending_mask = req.branch_mask;
            end
            if (res_valid && res_ready) begin
                outstanding--;
            end
        end
    end

    always @(negedge clock) begin
        if (UUT.props.fail_count != 0) begin
            $display("a concurrent assertion on bp_frontend failed");
            end_with_failure();
        end
    end

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        res_valid = 1'b0;
        res = '0;
        draw = $urandom(32'h8848_eded);
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("reset_rsp_valid", 0, 32'(rsp_valid));
        check_value("reset_redirect_valid", 0, 32'(redirect_valid));
        check_value("reset_res_ready", 0, 32'(res_ready));
        check_value("reset_req_ready", 0, 32'(req_ready));

        // cold tables, so nothing is taken
        pc = random_pc();
        draw = $urandom();
        mask = draw[1:0];
        send_group(pc, mask, 1'b0);
        wait_response(got, lag);
        check_value("first_latency", 0, 32'(lag));
        check_value("first_taken_mask", 0, 32'(got.taken_mask));
        check_value("first_next_pc", pc + 32'd8, got.next_pc);
        drain($countones(mask));

        // back-pressure holds the response
        pc = random_pc();
        send_group(pc, 2'b11, 1'b1);
        wait_response(got, lag);
        for (int i = 0; i < 3; i++) begin
            @(negedge clock);
            check_value("held_rsp_valid", 1, 32'(rsp_valid));
            check_value("held_next_pc", pc + 32'd8, rsp.next_pc);
            check_value("held_req_ready", 0, 32'(req_ready));
        end
        rsp_ready = 1'b1;
        drain(2);

        for (int g = 0; g < 12; g++) begin
            pc = random_pc();
            draw = $urandom();
            mask = draw[1:0];
            send_group(pc, mask, 1'b0);
            wait_response(got, lag);
            check_value("random_next_pc", pc + 32'd8, got.next_pc);
            drain($countones(mask));
        end

        // four full groups fill the tracker
        for (int g = 0; g < 4; g++) begin
            send_group(random_pc(), 2'b11, 1'b0);
            wait_response(got, lag);
        end
        @(negedge clock);
        check_value("full_req_ready", 0, 32'(req_ready));
        drain(8);

        // two taken resolves, both mispredicted, train the bimodal counter to 2
        pc = 32'h0000_1040;
        target = 32'h0000_2200;
        send_group(pc, 2'b01, 1'b0);
        wait_response(got, lag);
        check_value("train1_taken_mask", 0, 32'(got.taken_mask));
        resolve_one(1'b1, target);
        check_redirect("train1", target);
        send_group(pc, 2'b01, 1'b1);
        wait_response(got, lag);
        check_value("train2_taken_mask", 0, 32'(got.taken_mask));
        resolve_one(1'b1, target);
        check_redirect("train2", target);
        rsp_ready = 1'b1;

        // not-taken groups shift the history back to zero
        for (int g = 0; g < 3; g++) begin
            send_group(32'h0000_8000 + addr_t'(8 * g), 2'b11, 1'b0);
            wait_response(got, lag);
            drain(2);
        end

        send_group(pc, 2'b01, 1'b0);
        wait_response(got, lag);
        check_value("trained_taken_mask", 32'h1, 32'(got.taken_mask));
        check_value("trained_keep_mask", 32'h1, 32'(got.keep_mask));
        check_value("trained_next_pc", target, got.next_pc);
        check_value("trained_bimodal", 1, 32'(got.packets[0].bimodal_taken));
        check_value("trained_gshare", 0, 32'(got.packets[0].gshare_taken));
        resolve_one(1'b1, target);
        check_value("trained_redirect_valid", 0, 32'(redirect_valid));
        check_value("trained_res_ready", 0, 32'(res_ready));

        @(negedge clock);
        if (UUT.props.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

//--- src.f
bp_pkg.sv
btb.sv
tournament_predictor.sv
branch_tracker.sv
fetch_ctrl.sv
bp_frontend.sv
bp_frontend_props.sv
bp_frontend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bp_frontend simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module bp_frontend_tb \
    -f src.f -o bp_frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# a higher error limit lets the testbench report a failed assertion itself
./obj_dir/bp_frontend_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
